// File: sim.f
+incdir+include
src/csr_pkg.sv
src/csr_issue.sv
src/trap_ctrl.sv
src/csr_regfile.sv
src/csr_resp.sv
src/csr_stage.sv
tb/csr_stage_assert.sv
tb/tb_csr_stage.sv

// File: Makefile
TOP = tb_csr_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// File: tb/csr_testdata.txt
# cmd imm op1 hazard ready mtime mtimecmp cycle time pc rdata cmd_out trap_vector stall mask
# mask bits: 3 rdata, 2 cmd_out, 1 trap_vector, 0 stall
1 340 12345678 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
2 340 0000ff00 0 0 0 1 200000001 400000003 0 12345678 2 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
3 340 0000000f 0 0 0 1 200000001 400000003 0 1234ff78 3 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 340 0 0 0 0 1 200000001 400000003 0 1234ff70 0 0 0 d
1 304 ffffffff 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
3 304 00000200 0 0 0 1 200000001 400000003 0 00000aaa 3 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 304 0 0 0 0 1 200000001 400000003 0 000008aa 0 0 0 d
1 303 ffffffff 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 303 0 0 0 0 1 200000001 400000003 0 00000080 0 0 0 d
1 305 80000100 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
1 105 80000200 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
4 000 0 0 0 0 1 200000001 400000003 0 0 4 80000100 0 f
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 342 0 0 0 0 1 200000001 400000003 0 0000000b 0 0 0 d
1 300 ffffffff 0 0 0 1 200000001 400000003 0 00001800 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 300 0 0 0 0 1 200000001 400000003 0 000019aa 0 0 0 d
1 300 000000aa 0 0 0 1 200000001 400000003 0 000019aa 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
1 341 00000400 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
5 000 0 0 0 0 1 200000001 400000003 0 0 5 00000400 0 f
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 c00 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
1 306 00000007 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 c01 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
1 106 00000007 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 c01 0 0 0 0 1 200000001 400000003 0 00000003 0 0 0 d
0 c81 0 0 0 0 1 200000001 400000003 0 00000004 0 0 0 d
4 000 0 0 0 0 1 200000001 400000003 0 0 4 80000100 0 f
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 342 0 0 0 0 1 200000001 400000003 0 00000008 0 0 0 d
0 c80 0 0 0 0 1 200000001 400000003 0 00000002 0 0 0 d
0 c00 0 0 0 0 1 200000001 400000003 0 00000001 0 0 0 d
1 303 00000000 0 0 0 1 200000001 400000003 0 00000080 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 fff 0 0 0 10 10 200000001 400000003 0 0 0 0 1 d
0 fff 0 0 1 10 10 200000001 400000003 1000 0 4 80000100 1 f
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 341 0 0 0 0 1 200000001 400000003 0 00001000 0 0 0 d
0 342 0 0 0 0 1 200000001 400000003 0 80000007 0 0 0 d
1 303 00000080 0 0 0 1 200000001 400000003 0 0 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
1 300 00000802 0 0 0 1 200000001 400000003 0 000018a2 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
1 341 00002000 0 0 0 1 200000001 400000003 0 00001000 1 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
5 000 0 0 0 0 1 200000001 400000003 0 0 5 00002000 0 f
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 fff 0 0 1 20 10 200000001 400000003 3000 0 4 80000200 1 f
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 141 0 0 0 0 1 200000001 400000003 0 00003000 0 0 0 d
0 142 0 0 0 0 1 200000001 400000003 0 80000005 0 0 0 d
1 140 deadbeef 1 0 0 1 200000001 400000003 0 0 0 0 0 d
0 fff 0 0 0 0 1 200000001 400000003 0 0 0 0 0 d
0 140 0 0 0 0 1 200000001 400000003 0 00000000 0 0 0 d
0 341 0 1 0 0 1 200000001 400000003 0 00000000 0 0 0 d

// File: tb/tb_csr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_stage;

    logic        clk;
    logic        rst;
    logic [63:0] cycle, time_v, mtime, mtimecmp;
    logic        branch_hazard, interrupt_ready;
    logic [2:0]  csr_cmd;
    logic [31:0] op1_data, imm_i, fetch_pc;
    wire  [2:0]  csr_cmd_out;
    wire  [31:0] csr_rdata, trap_vector;
    wire         stall_may_interrupt;
    int          errors;

    csr_stage dut0 (
        .clk, .rst, .cycle, .time_val(time_v), .mtime, .mtimecmp, .branch_hazard,
        .csr_cmd, .op1_data, .imm_i, .interrupt_ready, .fetch_pc,
        .csr_cmd_out, .csr_rdata, .trap_vector, .stall_may_interrupt
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic drive_idle();
        csr_cmd         = 3'd0;
        imm_i           = 32'hfff;
        op1_data        = '0;
        branch_hazard   = 1'b0;
        interrupt_ready = 1'b0;
        mtime           = '0;
        mtimecmp        = 64'd1;
        cycle           = '0;
        time_v          = '0;
        fetch_pc        = '0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        int          waited;
        string       line;
        logic [2:0]  v_cmd, e_cmd;
        logic [31:0] v_imm, v_op1, v_pc, e_rdata, e_tv;
        logic        v_hz, v_rdy, e_stall, stall_seen;
        logic [63:0] v_mtime, v_cmp, v_cycle, v_time;
        logic [3:0]  mask;

        errors = 0;
        rst = 1'b1;
        drive_idle();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        #2 rst = 1'b0;

        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 20) begin
                $display("Timeout: outputs did not go idle after reset");
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end while (csr_cmd_out !== 3'd0);

        fd = $fopen("tb/csr_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file tb/csr_testdata.txt");
            $display("ERRORS FOUND");
            $fatal(1, "missing stimulus");
        end

        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (line_no > 1000) begin
                $display("Timeout: test data file has too many lines");
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
            // Comment and blank lines give fewer fields
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_cmd, v_imm, v_op1, v_hz, v_rdy, v_mtime, v_cmp, v_cycle,
                        v_time, v_pc, e_rdata, e_cmd, e_tv, e_stall, mask);
            if (n == 15) begin
                #1;
                csr_cmd         = v_cmd;
                imm_i           = v_imm;
                op1_data        = v_op1;
                branch_hazard   = v_hz;
                interrupt_ready = v_rdy;
                mtime           = v_mtime;
                mtimecmp        = v_cmp;
                cycle           = v_cycle;
                time_v          = v_time;
                fetch_pc        = v_pc;
                #10 stall_seen = stall_may_interrupt;
                @(posedge clk);
                #1;
                if (mask[3]) check($sformatf("line %0d rdata", line_no), csr_rdata, e_rdata);
                if (mask[2]) check($sformatf("line %0d cmd_out", line_no),
                                   {29'b0, csr_cmd_out}, {29'b0, e_cmd});
                if (mask[1]) check($sformatf("line %0d trap_vector", line_no),
                                   trap_vector, e_tv);
                if (mask[0]) check($sformatf("line %0d stall", line_no),
                                   {31'b0, stall_seen}, {31'b0, e_stall});
            end
        end
        $fclose(fd);
        drive_idle();

        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/csr_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage_assert import csr_pkg::*; (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic [2:0]  csr_cmd_out,
    input wire logic        stall_may_interrupt,
    input wire logic        interrupt_ready,
    input wire logic [63:0] mtime,
    input wire logic [63:0] mtimecmp
);

    // Outputs idle right after reset
    cmd_idle_after_reset: assert property (@(posedge clk) rst |=> csr_cmd_out == CMD_NONE)
        else $error("csr_cmd_out not idle after reset");

    stall_needs_timer: assert property (@(posedge clk) disable iff (rst)
        stall_may_interrupt |-> mtime >= mtimecmp)
        else $error("stall raised before mtime reached mtimecmp");

    // A taken timer trap is reported as an ecall
    trap_gives_ecall: assert property (@(posedge clk) disable iff (rst)
        stall_may_interrupt && interrupt_ready |=> csr_cmd_out == CMD_ECALL)
        else $error("timer trap did not produce an ecall");

endmodule

bind csr_stage csr_stage_assert u_assert (
    .clk, .rst, .csr_cmd_out, .stall_may_interrupt, .interrupt_ready, .mtime, .mtimecmp
);

`default_nettype wire

// File: src/csr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage import csr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [63:0] cycle,
    input  wire logic [63:0] time_val,
    input  wire logic [63:0] mtime,
    input  wire logic [63:0] mtimecmp,
    input  wire logic        branch_hazard,
    input  wire logic [2:0]  csr_cmd,
    input  wire logic [31:0] op1_data,
    input  wire logic [31:0] imm_i,
    input  wire logic        interrupt_ready,
    input  wire logic [31:0] fetch_pc,
    output logic      [2:0]  csr_cmd_out,
    output logic      [31:0] csr_rdata,
    output logic      [31:0] trap_vector,
    output logic             stall_may_interrupt
);

    csr_cmd_e    cmd_in, cmd_out;
    csr_req_t    req_now, req_saved;
    logic [31:0] wdata, mtvec, stvec, mepc;
    irq_state_t  irq;
    trap_evt_t   evt;
    logic        trap_taken;

    assign cmd_in      = csr_cmd_e'(csr_cmd);
    assign csr_cmd_out = cmd_out;

    csr_issue u_issue (
        .clk, .rst, .branch_hazard, .trap_taken, .csr_cmd(cmd_in), .op1_data, .imm_i,
        .rdata(csr_rdata), .req_now, .req_saved, .wdata
    );

    trap_ctrl u_trap (
        .cmd(req_now.cmd), .irq, .mtime, .mtimecmp, .interrupt_ready, .fetch_pc,
        .stall_may_interrupt, .trap_taken, .evt
    );

    csr_regfile u_regfile (
        .clk, .rst, .req_now, .req_saved, .wdata, .evt, .cycle, .time_val,
        .rdata(csr_rdata), .irq, .mtvec, .stvec, .mepc
    );

    csr_resp u_resp (
        .clk, .rst, .cmd(req_now.cmd), .evt, .mtvec, .stvec, .mepc,
        .csr_cmd_out(cmd_out), .trap_vector
    );

endmodule

`default_nettype wire

// File: src/csr_resp.sv
`timescale 1ns/1ps
`default_nettype none

module csr_resp import csr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  csr_cmd_e         cmd,
    input  trap_evt_t        evt,
    input  wire logic [31:0] mtvec,
    input  wire logic [31:0] stvec,
    input  wire logic [31:0] mepc,
    output csr_cmd_e         csr_cmd_out,
    output logic      [31:0] trap_vector
);

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_cmd_out <= CMD_NONE;
            trap_vector <= '0;
        end else begin
            // Timer trap is reported downstream as an ecall
            if (evt.kind inside {TRAP_TIMER_M, TRAP_TIMER_S}) begin
                csr_cmd_out <= CMD_ECALL;
            end else begin
                csr_cmd_out <= cmd;
            end
            case (evt.kind)
                TRAP_TIMER_M, TRAP_ECALL: trap_vector <= mtvec;
                TRAP_TIMER_S:             trap_vector <= stvec;
                TRAP_MRET:                trap_vector <= mepc;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile import csr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  csr_req_t         req_now,
    input  csr_req_t         req_saved,
    input  wire logic [31:0] wdata,
    input  trap_evt_t        evt,
    input  wire logic [63:0] cycle,
    input  wire logic [63:0] time_val,
    output logic      [31:0] rdata,
    output irq_state_t       irq,
    output logic      [31:0] mtvec,
    output logic      [31:0] stvec,
    output logic      [31:0] mepc
);

    priv_e       mode;
    logic [1:0]  mpp;
    logic        spp, mpie, spie, st_mie, st_sie;
    // Order is meie, seie, mtie, stie, msie, ssie
    logic [5:0]  mie_en;
    logic        mideleg_mtie;
    logic [2:0]  mcounteren, scounteren;
    logic [31:0] mscratch, mcause, sscratch, sepc, scause;
    csr_word_u   st_rd, st_wr;
    logic        cy_ok, tm_ok;
    logic [31:0] rd_next;

    // Lower modes need the enable bits of every mode above them
    function automatic logic cnt_ok(input priv_e m, input logic men, input logic sen);
        return m == PRIV_M || (men && (m == PRIV_S || (m == PRIV_U && sen)));
    endfunction

    always_comb begin
        st_rd.raw     = '0;
        st_rd.st.mpp  = mpp;
        st_rd.st.spp  = spp;
        st_rd.st.mpie = mpie;
        st_rd.st.spie = spie;
        st_rd.st.mie  = st_mie;
        st_rd.st.sie  = st_sie;
        st_wr.raw     = wdata;
    end

    assign cy_ok = cnt_ok(mode, mcounteren[0], scounteren[0]);
    assign tm_ok = cnt_ok(mode, mcounteren[1], scounteren[1]);

    always_comb begin
        case (req_now.addr)
            CSR_ADDR_CYCLE:      rd_next = cy_ok ? cycle[31:0] : '0;
            CSR_ADDR_TIME:       rd_next = tm_ok ? time_val[31:0] : '0;
            CSR_ADDR_CYCLEH:     rd_next = cy_ok ? cycle[63:32] : '0;
            CSR_ADDR_TIMEH:      rd_next = tm_ok ? time_val[63:32] : '0;
            CSR_ADDR_MSTATUS:    rd_next = st_rd.raw;
            CSR_ADDR_MIDELEG:    rd_next = {24'b0, mideleg_mtie, 7'b0};
            CSR_ADDR_MIE:        rd_next = {20'b0, mie_en[5], 1'b0, mie_en[4], 1'b0,
                                            mie_en[3], 1'b0, mie_en[2], 1'b0,
                                            mie_en[1], 1'b0, mie_en[0], 1'b0};
            CSR_ADDR_MTVEC:      rd_next = mtvec;
            CSR_ADDR_MCOUNTEREN: rd_next = {29'b0, mcounteren};
            CSR_ADDR_MSCRATCH:   rd_next = mscratch;
            CSR_ADDR_MEPC:       rd_next = mepc;
            CSR_ADDR_MCAUSE:     rd_next = mcause;
            CSR_ADDR_STVEC:      rd_next = stvec;
            CSR_ADDR_SCOUNTEREN: rd_next = {29'b0, scounteren};
            CSR_ADDR_SSCRATCH:   rd_next = sscratch;
            CSR_ADDR_SEPC:       rd_next = sepc;
            CSR_ADDR_SCAUSE:     rd_next = scause;
            default:             rd_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= rd_next;
        end
    end

    assign irq = '{mode: mode, mstatus_mie: st_mie, mstatus_sie: st_sie,
                   mie_mtie: mie_en[3], mie_stie: mie_en[2], mideleg_mtie: mideleg_mtie};

    always_ff @(posedge clk) begin
        if (rst) begin
            mode         <= PRIV_M;
            mpp          <= PRIV_M;
            {spp, mpie, spie, st_mie, st_sie} <= '0;
            mie_en       <= '0;
            mideleg_mtie <= 1'b0;
            mcounteren   <= '0;
            scounteren   <= '0;
            {mtvec, mscratch, mepc, mcause} <= '0;
            {stvec, sscratch, sepc, scause} <= '0;
        end else begin
            if (req_saved.cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR}) begin
                case (req_saved.addr)
                    CSR_ADDR_MSTATUS: begin
                        mpp    <= st_wr.st.mpp;
                        spp    <= st_wr.st.spp;
                        mpie   <= st_wr.st.mpie;
                        spie   <= st_wr.st.spie;
                        st_mie <= st_wr.st.mie;
                        st_sie <= st_wr.st.sie;
                    end
                    CSR_ADDR_MIDELEG:    mideleg_mtie <= wdata[7];
                    CSR_ADDR_MIE:        mie_en <= {wdata[11], wdata[9], wdata[7],
                                                    wdata[5], wdata[3], wdata[1]};
                    CSR_ADDR_MTVEC:      mtvec <= wdata;
                    CSR_ADDR_MCOUNTEREN: mcounteren <= wdata[2:0];
                    CSR_ADDR_MSCRATCH:   mscratch <= wdata;
                    CSR_ADDR_MEPC:       mepc <= wdata;
                    CSR_ADDR_MCAUSE:     mcause <= wdata;
                    CSR_ADDR_STVEC:      stvec <= wdata;
                    CSR_ADDR_SCOUNTEREN: scounteren <= wdata[2:0];
                    CSR_ADDR_SSCRATCH:   sscratch <= wdata;
                    CSR_ADDR_SEPC:       sepc <= wdata;
                    CSR_ADDR_SCAUSE:     scause <= wdata;
                    default: ;
                endcase
            end
            // Trap side effects win over a write in the same cycle
            case (evt.kind)
                TRAP_TIMER_M: begin
                    mpp    <= mode;
                    mpie   <= st_mie;
                    st_mie <= 1'b0;
                    mepc   <= evt.epc;
                    mcause <= CAUSE_M_TIMER;
                    mode   <= PRIV_M;
                end
                TRAP_TIMER_S: begin
                    spp    <= mode[0];
                    spie   <= st_sie;
                    st_sie <= 1'b0;
                    sepc   <= evt.epc;
                    scause <= CAUSE_S_TIMER;
                    mode   <= PRIV_S;
                end
                TRAP_ECALL: begin
                    mcause <= CAUSE_ECALL_BASE + {30'b0, mode};
                    mode   <= PRIV_M;
                end
                TRAP_MRET: begin
                    mode   <= priv_e'(mpp);
                    mpp    <= PRIV_U;
                    st_mie <= mpie;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import csr_pkg::*; (
    input  csr_cmd_e         cmd,
    input  irq_state_t       irq,
    input  wire logic [63:0] mtime,
    input  wire logic [63:0] mtimecmp,
    input  wire logic        interrupt_ready,
    input  wire logic [31:0] fetch_pc,
    output logic             stall_may_interrupt,
    output logic             trap_taken,
    output trap_evt_t        evt
);

    logic m_enabled;
    logic s_enabled;

    // Machine timer not delegated and not masked
    assign m_enabled = irq.mode == PRIV_M && irq.mie_mtie && !irq.mideleg_mtie &&
                       irq.mstatus_mie;
    assign s_enabled = irq.mode == PRIV_S && irq.mie_stie && irq.mstatus_sie;

    assign stall_may_interrupt = (mtime >= mtimecmp) && (m_enabled || s_enabled);
    assign trap_taken          = stall_may_interrupt && interrupt_ready;

    always_comb begin
        evt.epc = fetch_pc;
        if (trap_taken) begin
            // Delegated timer goes to S unless already in M
            if (irq.mode != PRIV_M && irq.mideleg_mtie) begin
                evt.kind = TRAP_TIMER_S;
            end else begin
                evt.kind = TRAP_TIMER_M;
            end
        end else begin
            case (cmd)
                CMD_ECALL: evt.kind = TRAP_ECALL;
                CMD_MRET:  evt.kind = TRAP_MRET;
                default:   evt.kind = TRAP_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/csr_issue.sv
`timescale 1ns/1ps
`default_nettype none

module csr_issue import csr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        branch_hazard,
    input  wire logic        trap_taken,
    input  csr_cmd_e         csr_cmd,
    input  wire logic [31:0] op1_data,
    input  wire logic [31:0] imm_i,
    input  wire logic [31:0] rdata,
    output csr_req_t         req_now,
    output csr_req_t         req_saved,
    output logic      [31:0] wdata
);

    // Hazard turns the request into a no-op at an unmapped address
    always_comb begin
        if (branch_hazard) begin
            req_now = '{cmd: CMD_NONE, addr: 12'hfff, op1: '1};
        end else begin
            req_now = '{cmd: csr_cmd, addr: imm_i[11:0], op1: op1_data};
        end
    end

    // Write phase runs one cycle behind the read
    always_ff @(posedge clk) begin
        req_saved.addr <= req_now.addr;
        req_saved.op1  <= req_now.op1;
        if (rst || trap_taken) begin
            req_saved.cmd <= CMD_NONE;
        end else begin
            req_saved.cmd <= req_now.cmd;
        end
    end

    // rdata here is the old value read for the saved request
    always_comb begin
        case (req_saved.cmd)
            CMD_WRITE: wdata = req_saved.op1;
            CMD_SET:   wdata = rdata | req_saved.op1;
            CMD_CLEAR: wdata = rdata & ~req_saved.op1;
            default:   wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/csr_pkg.sv
`default_nettype none

package csr_pkg;

`include "csr_addr.svh"

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    typedef struct packed {
        csr_cmd_e    cmd;
        logic [11:0] addr;
        logic [31:0] op1;
    } csr_req_t;

    // Architectural bit positions of the kept mstatus fields
    typedef struct packed {
        logic [18:0] zero_hi;
        logic [1:0]  mpp;
        logic [1:0]  zero_vs;
        logic        spp;
        logic        mpie;
        logic        zero_ube;
        logic        spie;
        logic        zero_4;
        logic        mie;
        logic        zero_2;
        logic        sie;
        logic        zero_0;
    } mstatus_t;

    typedef union packed {
        logic [31:0] raw;
        mstatus_t    st;
    } csr_word_u;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_TIMER_M,
        TRAP_TIMER_S,
        TRAP_ECALL,
        TRAP_MRET
    } trap_kind_e;

    typedef struct packed {
        trap_kind_e  kind;
        logic [31:0] epc;
    } trap_evt_t;

    typedef struct packed {
        priv_e mode;
        logic  mstatus_mie;
        logic  mstatus_sie;
        logic  mie_mtie;
        logic  mie_stie;
        logic  mideleg_mtie;
    } irq_state_t;

endpackage

`default_nettype wire

// File: include/csr_addr.svh
`ifndef CSR_ADDR_SVH
`define CSR_ADDR_SVH

// Read-only counters
localparam logic [11:0] CSR_ADDR_CYCLE      = 12'hc00;
localparam logic [11:0] CSR_ADDR_TIME       = 12'hc01;
localparam logic [11:0] CSR_ADDR_CYCLEH     = 12'hc80;
localparam logic [11:0] CSR_ADDR_TIMEH      = 12'hc81;

// Machine mode
localparam logic [11:0] CSR_ADDR_MSTATUS    = 12'h300;
localparam logic [11:0] CSR_ADDR_MIDELEG    = 12'h303;
localparam logic [11:0] CSR_ADDR_MIE        = 12'h304;
localparam logic [11:0] CSR_ADDR_MTVEC      = 12'h305;
localparam logic [11:0] CSR_ADDR_MCOUNTEREN = 12'h306;
localparam logic [11:0] CSR_ADDR_MSCRATCH   = 12'h340;
localparam logic [11:0] CSR_ADDR_MEPC       = 12'h341;
localparam logic [11:0] CSR_ADDR_MCAUSE     = 12'h342;

// Supervisor mode
localparam logic [11:0] CSR_ADDR_STVEC      = 12'h105;
localparam logic [11:0] CSR_ADDR_SCOUNTEREN = 12'h106;
localparam logic [11:0] CSR_ADDR_SSCRATCH   = 12'h140;
localparam logic [11:0] CSR_ADDR_SEPC       = 12'h141;
localparam logic [11:0] CSR_ADDR_SCAUSE     = 12'h142;

// Top bit of a cause code marks an interrupt
localparam logic [31:0] CAUSE_M_TIMER       = 32'h8000_0007;
localparam logic [31:0] CAUSE_S_TIMER       = 32'h8000_0005;
localparam logic [31:0] CAUSE_ECALL_BASE    = 32'd8;

`endif
